/* vlog.f */
uart_pkg.sv
baud_tick.sv
uart_tx.sv
uart_rx.sv
uart_status.sv
buart_top.sv
tb_buart.sv

/* tb_buart.sv */
/* buart testbench
   random full-duplex traffic against line models on tx and rx */

`timescale 1ns/1ns

module tb_buart;

  localparam int BIT_CYC    = 50;              // clocks per bit, 25 MHz at 500 kbaud
  localparam int FRAME_CYC  = 10 * BIT_CYC;    // start + 8 data + stop
  localparam int RX_LIMIT   = 600;             // start edge to capture
  localparam int IDLE_LIMIT = 1000;            // longest wait for tx to go idle

  logic       clk;
  logic       resetq;
  logic       rx;
  logic       tx;
  logic       wr;
  logic [7:0] tx_data;
  logic       busy;
  logic       rd;
  logic       valid;
  logic [7:0] rx_data;
  logic       overrun;
  logic       frame_err;

  integer     seed;
  logic [7:0] tx_expect[$];    // written bytes, oldest first

  // host-side model of the holding register and flags
  logic       exp_valid;
  logic [7:0] exp_data;
  logic       exp_overrun;
  logic       exp_ferr;

  buart_top #(
    .CLK_FREQ  (25_000_000),
    .BAUD      (500_000)
  ) dut0 (
    .clk       (clk),
    .resetq    (resetq),
    .rx        (rx),
    .tx        (tx),
    .wr        (wr),
    .tx_data   (tx_data),
    .busy      (busy),
    .rd        (rd),
    .valid     (valid),
    .rx_data   (rx_data),
    .overrun   (overrun),
    .frame_err (frame_err)
  );

  always #20 clk = ~clk;       // 40 ns period

  function automatic logic [7:0] rand_byte();
    logic [31:0] r;
    r = $random(seed);
    return r[7:0];
  endfunction

  task automatic stop_run();
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped at first failure");
  endtask

  task automatic check_value(input string name, input logic [7:0] expected,
                             input logic [7:0] actual);
    if (actual !== expected) begin
      $display("[ERROR] %0t ns: %s expected %02h, actual %02h",
               $time, name, expected, actual);
      stop_run();
    end
  endtask

  task automatic timeout_fail(input string what);
    $display("%0t ns: %s", $time, what);
    stop_run();
  endtask

  // status outputs against the model, data only when a byte is held
  task automatic compare_status();
    check_value("valid", exp_valid, valid);
    check_value("overrun", exp_overrun, overrun);
    check_value("frame_err", exp_ferr, frame_err);
    if (exp_valid) check_value("rx_data", exp_data, rx_data);
  endtask

  task automatic wait_tx_idle();
    int n;
    n = 0;
    @(negedge clk);
    while (busy !== 1'b0) begin
      n++;
      if (n > IDLE_LIMIT) timeout_fail("transmitter stayed busy, no write possible");
      @(negedge clk);
    end
    check_value("tx", 8'h01, tx);              // line idles high
  endtask

  // write one byte, then decode the frame on tx at mid-bit
  task automatic send_tx_byte(input logic [7:0] b);
    logic [7:0] want;
    logic [7:0] got;
    int         cyc;
    wait_tx_idle();
    @(posedge clk);
    wr      <= 1'b1;
    tx_data <= b;
    tx_expect.push_back(b);
    @(posedge clk);                            // dut takes the write here
    wr      <= 1'b0;
    tx_data <= ~b;                             // junk for the stray write
    @(negedge clk);
    check_value("tx", 8'h00, tx);              // start bit right away
    check_value("busy", 8'h01, busy);
    got = 8'h00;
    for (cyc = 1; cyc <= FRAME_CYC; cyc++) begin
      @(posedge clk);
      wr <= (cyc == 2 * BIT_CYC);              // stray wr inside bit 1, must be dropped
      @(negedge clk);
      if (cyc % BIT_CYC == BIT_CYC / 2) begin
        if (cyc < BIT_CYC) check_value("tx", 8'h00, tx);
        else if (cyc < 9 * BIT_CYC) got[cyc / BIT_CYC - 1] = tx;   // lsb first
        else check_value("tx", 8'h01, tx);     // stop bit
      end
      check_value("busy", cyc < FRAME_CYC, busy);   // drops exactly at frame end
    end
    want = tx_expect.pop_front();
    check_value("tx frame byte", want, got);
  endtask

  // drive one frame on rx, wait for the capture, then update the model
  task automatic rx_frame(input logic [7:0] b, input logic stop_bit);
    logic was_valid;
    logic seen;
    int   cyc;
    int   slot;
    was_valid = exp_valid;
    seen      = 1'b0;
    for (cyc = 0; cyc < RX_LIMIT; cyc++) begin
      @(posedge clk);
      slot = cyc / BIT_CYC;
      if (slot == 0) rx <= 1'b0;               // start
      else if (slot <= 8) rx <= b[slot - 1];
      else if (slot == 9) rx <= stop_bit;
      else rx <= 1'b1;                         // back to idle
      @(negedge clk);
      // a held byte shows the capture through overrun instead of valid
      if (!seen) seen = was_valid ? overrun : valid;
      if (seen && cyc >= FRAME_CYC) break;     // line must be high again
    end
    if (!seen) timeout_fail("received byte never captured");
    exp_overrun = exp_overrun | exp_valid;
    exp_valid   = 1'b1;
    exp_data    = b;
    exp_ferr    = exp_ferr | ~stop_bit;
    compare_status();
  endtask

  // rd pulse, result checked the cycle after
  task automatic read_byte();
    @(posedge clk);
    rd <= 1'b1;
    @(posedge clk);
    rd <= 1'b0;
    @(negedge clk);
    if (exp_valid) begin                       // no effect with nothing held
      exp_valid   = 1'b0;
      exp_overrun = 1'b0;
      exp_ferr    = 1'b0;
    end
    compare_status();
  endtask

  initial begin
    logic [7:0] b1;
    logic [7:0] b2;
    clk         = 1'b0;
    resetq      = 1'b0;
    rx          = 1'b1;
    wr          = 1'b0;
    rd          = 1'b0;
    tx_data     = 8'h00;
    seed        = 32'h7bf2_06d2;
    exp_valid   = 1'b0;
    exp_data    = 8'h00;
    exp_overrun = 1'b0;
    exp_ferr    = 1'b0;
    repeat (5) @(posedge clk);
    resetq <= 1'b1;
    @(negedge clk);
    check_value("tx", 8'h01, tx);
    check_value("busy", 8'h00, busy);
    compare_status();
    read_byte();                               // rd with valid low

    // transmit alone
    repeat (40) send_tx_byte(rand_byte());

    // receive alone, good stop bits
    repeat (8) begin
      rx_frame(rand_byte(), 1'b1);
      read_byte();
    end

    // overrun, second byte differs so the overwrite is visible
    b1 = rand_byte();
    b2 = b1 ^ 8'h5a;
    rx_frame(b1, 1'b1);
    rx_frame(b2, 1'b1);
    read_byte();

    // framing error, then a clean frame
    rx_frame(rand_byte(), 1'b0);
    read_byte();
    rx_frame(rand_byte(), 1'b1);
    read_byte();

    // both directions at once
    fork
      repeat (12) send_tx_byte(rand_byte());
      repeat (10) begin
        repeat (rand_byte() % 64) @(posedge clk);   // uneven gaps
        rx_frame(rand_byte(), (rand_byte() % 8) != 0);
        read_byte();
      end
    join

    $display("NO ERRORS");
    $finish;
  end

endmodule

/* buart_top.sv */
/* buart top level
   full-duplex 8N1 port, divider setup and wiring of tx, rx and status */

`timescale 1ns/1ns

module buart_top #(
  parameter int CLK_FREQ = 25_000_000,   // input clock, Hz
  parameter int BAUD     = 500_000       // line rate
) (
  input  logic                           clk,
  input  logic                           resetq,
  input  logic                           rx,          // serial in
  output logic                           tx,          // serial out
  input  logic                           wr,          // write strobe
  input  logic [uart_pkg::DATA_BITS-1:0] tx_data,
  output logic                           busy,        // transmitting
  input  logic                           rd,          // read strobe
  output logic                           valid,       // byte held
  output logic [uart_pkg::DATA_BITS-1:0] rx_data,
  output logic                           overrun,
  output logic                           frame_err
);

  // one bit period for tx, half a bit for rx sampling
  localparam int BIT_DIV  = CLK_FREQ / BAUD;
  localparam int HALF_DIV = CLK_FREQ / (2 * BAUD);

  logic                           tx_busy;
  logic                           rx_done;
  logic                           rx_ack;
  logic                           rx_stop_ok;
  logic [uart_pkg::DATA_BITS-1:0] rx_byte;

  uart_tx #(
    .BIT_DIV (BIT_DIV)
  ) tx0 (
    .clk     (clk),
    .resetq  (resetq),
    .wr      (wr),
    .tx_data (tx_data),
    .tx      (tx),
    .tx_busy (tx_busy)
  );

  uart_rx #(
    .HALF_DIV   (HALF_DIV)
  ) rx0 (
    .clk        (clk),
    .resetq     (resetq),
    .rx         (rx),
    .rx_ack     (rx_ack),
    .rx_done    (rx_done),
    .rx_byte    (rx_byte),
    .rx_stop_ok (rx_stop_ok)
  );

  uart_status status0 (
    .clk        (clk),
    .resetq     (resetq),
    .rx_done    (rx_done),
    .rx_byte    (rx_byte),
    .rx_stop_ok (rx_stop_ok),
    .tx_busy    (tx_busy),
    .rd         (rd),
    .rx_ack     (rx_ack),
    .rx_data    (rx_data),
    .valid      (valid),
    .overrun    (overrun),
    .frame_err  (frame_err),
    .busy       (busy)
  );

endmodule

/* uart_status.sv */
/* uart status block
   receive holding register, overrun and framing flags, host-side busy */

`timescale 1ns/1ns

module uart_status (
  input  logic                           clk,
  input  logic                           resetq,
  input  logic                           rx_done,     // engine holds a byte
  input  logic [uart_pkg::DATA_BITS-1:0] rx_byte,
  input  logic                           rx_stop_ok,
  input  logic                           tx_busy,     // from the tx bit counter
  input  logic                           rd,          // read strobe
  output logic                           rx_ack,      // frees the engine
  output logic [uart_pkg::DATA_BITS-1:0] rx_data,     // holding register
  output logic                           valid,
  output logic                           overrun,     // sticky until rd
  output logic                           frame_err,   // sticky until rd
  output logic                           busy
);

  logic rd_take;   // read that actually consumes a byte

  assign rd_take = rd & valid;

  // take every finished byte at once, the engine never stalls
  assign rx_ack = rx_done;

  // tx_busy comes straight off a flop in the transmitter
  assign busy = tx_busy;

  // flags, a new byte wins over a read in the same cycle
  always_ff @(posedge clk) begin
    if (!resetq) begin
      valid     <= 1'b0;
      overrun   <= 1'b0;
      frame_err <= 1'b0;
    end else begin
      if (rd_take) begin
        valid     <= 1'b0;
        overrun   <= 1'b0;
        frame_err <= 1'b0;
      end
      if (rx_done) begin
        valid <= 1'b1;
        // old byte still unread, it gets overwritten
        if (valid && !rd_take) overrun <= 1'b1;
        if (!rx_stop_ok) frame_err <= 1'b1;   // stop bit came in low
      end
    end
  end

  // holding register, overwritten on each new byte
  always_ff @(posedge clk) begin
    if (rx_done) rx_data <= rx_byte;
  end

endmodule

/* uart_rx.sv */
/* uart receiver
   synchronises rx, finds the start edge, samples mid-bit and checks the stop bit */

`timescale 1ns/1ns

module uart_rx #(
  parameter int HALF_DIV = 25     // clocks per half bit
) (
  input  logic                           clk,
  input  logic                           resetq,
  input  logic                           rx,          // async serial in
  input  logic                           rx_ack,      // byte taken by host side
  output logic                           rx_done,     // level while byte is held
  output logic [uart_pkg::DATA_BITS-1:0] rx_byte,
  output logic                           rx_stop_ok   // stop bit sampled high
);

  // half-tick numbering from the start edge
  // first sample after 3 half-ticks, then every 2
  localparam int FIRST_HT = 2;                           // count value at bit 0
  localparam int LAST_HT  = 2 * uart_pkg::DATA_BITS;     // count at last data bit
  localparam int STOP_HT  = LAST_HT + 2;                 // count at stop bit
  localparam int HW       = $clog2(STOP_HT + 1);

  uart_pkg::rx_state_t state;

  logic          rx_meta;       // first sync stage
  logic          rx_sync;       // second sync stage
  logic          rx_prev;       // for edge detect
  logic          start_edge;
  logic          half_tick;
  logic [HW-1:0] hcnt;          // half-ticks since start edge
  logic          data_sample;
  logic          stop_sample;

  assign start_edge = (state == uart_pkg::RX_IDLE) & rx_prev & ~rx_sync;
  assign rx_done    = (state == uart_pkg::RX_DONE);

  // bit 0 in RX_START, the rest at even counts in RX_DATA
  assign data_sample = half_tick & ~hcnt[0] &
                       (((state == uart_pkg::RX_START) && (hcnt == HW'(FIRST_HT))) ||
                        (state == uart_pkg::RX_DATA));
  assign stop_sample = half_tick & (state == uart_pkg::RX_STOP) &
                       (hcnt == HW'(STOP_HT));

  // half-bit timer, aligned to the start edge
  baud_tick #(
    .DIV     (HALF_DIV)
  ) half_timer (
    .clk     (clk),
    .resetq  (resetq),
    .restart (start_edge),
    .tick    (half_tick)
  );

  // two-flop sync plus one for the edge, all reset to idle level
  always_ff @(posedge clk) begin
    if (!resetq) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  // frame FSM
  always_ff @(posedge clk) begin
    if (!resetq) begin
      state <= uart_pkg::RX_IDLE;
      hcnt  <= '0;
    end else begin
      case (state)
        uart_pkg::RX_IDLE: begin
          if (start_edge) begin
            state <= uart_pkg::RX_START;
            hcnt  <= '0;
          end
        end
        uart_pkg::RX_START: begin
          if (half_tick) begin
            hcnt <= hcnt + 1'b1;
            if (hcnt == HW'(FIRST_HT)) state <= uart_pkg::RX_DATA;  // bit 0 taken
          end
        end
        uart_pkg::RX_DATA: begin
          if (half_tick) begin
            hcnt <= hcnt + 1'b1;
            if (hcnt == HW'(LAST_HT)) state <= uart_pkg::RX_STOP;   // msb taken
          end
        end
        uart_pkg::RX_STOP: begin
          if (stop_sample) begin
            state <= uart_pkg::RX_DONE;
          end else if (half_tick) begin
            hcnt <= hcnt + 1'b1;
          end
        end
        uart_pkg::RX_DONE: begin
          if (rx_ack) state <= uart_pkg::RX_IDLE;  // back before next start bit
        end
        default: state <= uart_pkg::RX_IDLE;
      endcase
    end
  end

  // payload, shifted in lsb first
  always_ff @(posedge clk) begin
    if (data_sample) rx_byte <= {rx_sync, rx_byte[uart_pkg::DATA_BITS-1:1]};
    if (stop_sample) rx_stop_ok <= rx_sync;
  end

endmodule

/* uart_tx.sv */
/* uart transmitter
   serialises one byte into a start/data/stop frame on tx */

`timescale 1ns/1ns

module uart_tx #(
  parameter int BIT_DIV = 50      // clocks per bit
) (
  input  logic                           clk,
  input  logic                           resetq,
  input  logic                           wr,        // write strobe
  input  logic [uart_pkg::DATA_BITS-1:0] tx_data,
  output logic                           tx,        // serial out, idles high
  output logic                           tx_busy
);

  // bit counter holds 0..FRAME_BITS, 0 means idle
  localparam int CW = $clog2(uart_pkg::FRAME_BITS + 1);

  logic [CW-1:0]                    bitcount;
  logic [uart_pkg::DATA_BITS:0]     shifter;   // data plus stop bit
  logic                             sending;
  logic                             accept;    // wr taken this cycle
  logic                             bit_tick;

  assign sending = (bitcount != '0);
  assign tx_busy = sending;
  assign accept  = wr & ~sending;              // wr while busy is dropped

  // bit timer, restarted so the start bit lasts a full BIT_DIV
  baud_tick #(
    .DIV     (BIT_DIV)
  ) bit_timer (
    .clk     (clk),
    .resetq  (resetq),
    .restart (accept),
    .tick    (bit_tick)
  );

  // control state: line level and bit count
  always_ff @(posedge clk) begin
    if (!resetq) begin
      tx       <= 1'b1;                        // line idle
      bitcount <= '0;
    end else if (accept) begin
      tx       <= 1'b0;                        // start bit goes out now
      bitcount <= CW'(uart_pkg::FRAME_BITS);
    end else if (sending && bit_tick) begin
      tx       <= shifter[0];                  // next bit, lsb first
      bitcount <= bitcount - 1'b1;
    end
  end

  // frame shifter, loaded with stop bit on top of the byte
  always_ff @(posedge clk) begin
    if (accept) begin
      shifter <= {1'b1, tx_data};
    end else if (sending && bit_tick) begin
      shifter <= {1'b1, shifter[uart_pkg::DATA_BITS:1]};  // fill with ones
    end
  end

endmodule

/* baud_tick.sv */
/* baud tick generator
   restartable down-counter, one-cycle tick every DIV clocks */

`timescale 1ns/1ns

module baud_tick #(
  parameter int DIV = 50          // clocks per tick
) (
  input  logic clk,
  input  logic resetq,
  input  logic restart,           // realign, next tick DIV clocks out
  output logic tick
);

  // counter only has to hold DIV-1
  localparam int W = (DIV > 1) ? $clog2(DIV) : 1;
  localparam logic [W-1:0] RELOAD = W'(DIV - 1);

  logic [W-1:0] cnt;

  // tick while the count sits at zero
  assign tick = (cnt == '0);

  always_ff @(posedge clk) begin
    if (!resetq) begin
      cnt <= RELOAD;                // loaded, so no tick straight out of reset
    end else if (restart) begin
      cnt <= RELOAD;                // frame start, bit boundary from here
    end else if (tick) begin
      cnt <= RELOAD;                // wrap
    end else begin
      cnt <= cnt - 1'b1;
    end
  end

endmodule

/* uart_pkg.sv */
/* uart package
   frame constants and receive state type shared by the serial port */

package uart_pkg;

  // 8N1 frame layout
  localparam int DATA_BITS  = 8;              // payload bits, sent lsb first
  localparam int FRAME_BITS = DATA_BITS + 2;  // start + data + stop

  // receive engine states
  // idle waits for a falling edge on the synced line,
  // start waits three half-bits to land mid bit 0,
  // data samples every second half-tick,
  // stop samples the stop level,
  // done holds the byte until the status block takes it
  typedef enum logic [2:0] {
    RX_IDLE  = 3'd0,
    RX_START = 3'd1,
    RX_DATA  = 3'd2,
    RX_STOP  = 3'd3,
    RX_DONE  = 3'd4
  } rx_state_t;

endpackage
